// File: logic/rv_isa_pkg.sv
/*
 * RV32IM encodings as seen by the decode stage. The vector opcodes are not
 * listed and decode as illegal. NOP is encoded as zero.
 */
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // Operation codes handed to execute
    typedef enum logic [7:0] {
        NOP = 8'd0,
        LUI, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
        LB, LH, LW, LBU, LHU, SB, SH, SW,
        ECALL, EBREAK, SRET, MRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        INVALID
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } format_e;

    ////////////////////////////////////////
    // Instruction word, one view per format
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        opcode_e               opcode;
    } s_view_t;

    // Branch offset bits are scattered, bit 0 is implied
    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        opcode_e               opcode;
    } b_view_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } u_view_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } j_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
        s_view_t s;
        b_view_t b;
        u_view_t u;
        j_view_t j;
    } rv_inst_u;

endpackage

// File: logic/decode_pkg.sv
/*
 * Decode stage result types. A bubble is the all-zero output with op NOP
 * and the tag of the cycle that produced it.
 */
package decode_pkg;

    import rv_isa_pkg::*;

    localparam int TAG_W = 3;

    // Combinational decode of the current word
    typedef struct packed {
        op_e             op;
        format_e         format;
        logic [XLEN-1:0] imm;
    } decode_info_t;

    // Registered stage output towards execute
    typedef struct packed {
        logic [XLEN-1:0]       first_operand;
        logic [XLEN-1:0]       second_operand;
        logic [XLEN-1:0]       third_operand;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        op_e                   op;
        logic [TAG_W-1:0]      tag;
        logic                  illegal;
        logic                  misaligned;
        logic                  access_fault;
    } decode_out_t;

endpackage

// File: logic/inst_replay.sv
/*
 * Holds the word decoded last cycle. After a hazard or a stall the held
 * word is decoded again and instruction_i is ignored for that cycle.
 */
module inst_replay
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     enable_i,
    input  logic     hazard_i,
    input  rv_inst_u instruction_i,
    output rv_inst_u inst_o
);

    rv_inst_u held;
    logic     replay;

    always_ff @(posedge clk) begin
        held   <= inst_o;
        replay <= hazard_i | ~enable_i;
    end

    assign inst_o = replay ? held : instruction_i;

    // A bubbled or stalled word comes back unchanged on the next cycle
    a_replay_same_word: assert property (
        @(posedge clk) (hazard_i || !enable_i) |=> inst_o == $past(inst_o)
    );

endmodule

// File: logic/op_decoder.sv
/*
 * Pure combinational opcode decode. Anything not in the tables below,
 * vector opcodes included, yields INVALID.
 */
module op_decoder
    import rv_isa_pkg::*;
(
    input  rv_inst_u inst_i,
    output op_e      op_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        branch_op, load_op, store_op, op_imm_op, op_op, system_op;

    assign funct3 = inst_i.r.funct3;
    assign funct7 = inst_i.r.funct7;

    always_comb begin
        case (funct3)
            3'b000:  branch_op = BEQ;
            3'b001:  branch_op = BNE;
            3'b100:  branch_op = BLT;
            3'b101:  branch_op = BGE;
            3'b110:  branch_op = BLTU;
            3'b111:  branch_op = BGEU;
            default: branch_op = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  load_op = LB;
            3'b001:  load_op = LH;
            3'b010:  load_op = LW;
            3'b100:  load_op = LBU;
            3'b101:  load_op = LHU;
            default: load_op = INVALID;
        endcase
        case (funct3)
            3'b000:  store_op = SB;
            3'b001:  store_op = SH;
            3'b010:  store_op = SW;
            default: store_op = INVALID;
        endcase
    end

    // Shifts by immediate still check funct7
    always_comb begin
        case (funct3)
            3'b000:  op_imm_op = ADD;
            3'b001:  op_imm_op = (funct7 == 7'b0000000) ? SLL : INVALID;
            3'b010:  op_imm_op = SLT;
            3'b011:  op_imm_op = SLTU;
            3'b100:  op_imm_op = XOR;
            3'b101:  op_imm_op = (funct7 == 7'b0000000) ? SRL :
                                 (funct7 == 7'b0100000) ? SRA : INVALID;
            3'b110:  op_imm_op = OR;
            default: op_imm_op = AND;
        endcase
    end

    always_comb begin
        op_op = INVALID;
        case (funct7)
            7'b0000000: begin
                case (funct3)
                    3'b000:  op_op = ADD;
                    3'b001:  op_op = SLL;
                    3'b010:  op_op = SLT;
                    3'b011:  op_op = SLTU;
                    3'b100:  op_op = XOR;
                    3'b101:  op_op = SRL;
                    3'b110:  op_op = OR;
                    default: op_op = AND;
                endcase
            end
            7'b0100000: begin
                if (funct3 == 3'b000) op_op = SUB;
                if (funct3 == 3'b101) op_op = SRA;
            end
            // M extension
            7'b0000001: begin
                case (funct3)
                    3'b000:  op_op = MUL;
                    3'b001:  op_op = MULH;
                    3'b010:  op_op = MULHSU;
                    3'b011:  op_op = MULHU;
                    3'b100:  op_op = DIV;
                    3'b101:  op_op = DIVU;
                    3'b110:  op_op = REM;
                    default: op_op = REMU;
                endcase
            end
            default: op_op = INVALID;
        endcase
    end

    // Privileged forms need rs1 and rd zero, CSR forms only look at funct3
    always_comb begin
        system_op = INVALID;
        case (funct3)
            3'b000: begin
                if (inst_i.i.rs1 == '0 && inst_i.i.rd == '0) begin
                    case (inst_i.i.imm)
                        12'h000: system_op = ECALL;
                        12'h001: system_op = EBREAK;
                        12'h102: system_op = SRET;
                        12'h302: system_op = MRET;
                        12'h105: system_op = WFI;
                        default: system_op = INVALID;
                    endcase
                end
            end
            3'b001:  system_op = CSRRW;
            3'b010:  system_op = CSRRS;
            3'b011:  system_op = CSRRC;
            3'b101:  system_op = CSRRWI;
            3'b110:  system_op = CSRRSI;
            3'b111:  system_op = CSRRCI;
            default: system_op = INVALID;
        endcase
    end

    always_comb begin
        case (inst_i.r.opcode)
            OPC_LUI:      op_o = LUI;
            OPC_AUIPC:    op_o = ADD;
            OPC_JAL:      op_o = JAL;
            OPC_JALR:     op_o = JALR;
            OPC_BRANCH:   op_o = branch_op;
            OPC_LOAD:     op_o = load_op;
            OPC_STORE:    op_o = store_op;
            OPC_OP_IMM:   op_o = op_imm_op;
            OPC_OP:       op_o = op_op;
            // FENCE is executed as a NOP
            OPC_MISC_MEM: op_o = (funct3 == 3'b000) ? NOP : INVALID;
            OPC_SYSTEM:   op_o = system_op;
            default:      op_o = INVALID;
        endcase
    end

endmodule

// File: logic/imm_gen.sv
/*
 * Format classification and immediate assembly. Unknown opcodes fall into
 * R format and get a zero immediate.
 */
module imm_gen
    import rv_isa_pkg::*;
(
    input  rv_inst_u        inst_i,
    output format_e         format_o,
    output logic [XLEN-1:0] imm_o
);

    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    always_comb begin
        case (inst_i.r.opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: format_o = I_TYPE;
            OPC_STORE:                      format_o = S_TYPE;
            OPC_BRANCH:                     format_o = B_TYPE;
            OPC_LUI, OPC_AUIPC:             format_o = U_TYPE;
            OPC_JAL:                        format_o = J_TYPE;
            default:                        format_o = R_TYPE;
        endcase
    end

    ////////////////////////////////////////
    // Sign extended immediates per view
    ////////////////////////////////////////

    assign imm_i = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_s = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
    assign imm_b = {{19{inst_i.b.imm_12}}, inst_i.b.imm_12, inst_i.b.imm_11,
                    inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
    assign imm_u = {inst_i.u.imm_31_12, 12'b0};
    assign imm_j = {{11{inst_i.j.imm_20}}, inst_i.j.imm_20, inst_i.j.imm_19_12,
                    inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};

    always_comb begin
        case (format_o)
            I_TYPE:  imm_o = imm_i;
            S_TYPE:  imm_o = imm_s;
            B_TYPE:  imm_o = imm_b;
            U_TYPE:  imm_o = imm_u;
            J_TYPE:  imm_o = imm_j;
            default: imm_o = '0;
        endcase
    end

endmodule

// File: logic/hazard_unit.sv
/*
 * Single entry lock on the last accepted rd and on a preceding store.
 * CSR immediate forms count as rs1 and rs2 users, which may stall needlessly.
 */
module hazard_unit
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     enable_i,
    input  rv_inst_u inst_i,
    input  format_e  format_i,
    output logic     hazard_o
);

    logic [REG_ADDR_W-1:0] locked_rd;
    logic                  locked_mem;
    logic                  use_rs1, use_rs2, use_mem;
    logic                  hit_rs1, hit_rs2;

    // A bubble releases both locks
    always_ff @(posedge clk) begin
        if (reset) begin
            locked_rd  <= '0;
            locked_mem <= 1'b0;
        end else if (hazard_o) begin
            locked_rd  <= '0;
            locked_mem <= 1'b0;
        end else if (enable_i) begin
            locked_rd  <= inst_i.r.rd;
            locked_mem <= (inst_i.r.opcode == OPC_STORE);
        end
    end

    assign use_rs1 = format_i inside {R_TYPE, I_TYPE, S_TYPE, B_TYPE};
    assign use_rs2 = format_i inside {R_TYPE, S_TYPE, B_TYPE};
    assign use_mem = inst_i.r.opcode inside {OPC_LOAD, OPC_STORE};

    assign hit_rs1 = use_rs1 && inst_i.r.rs1 != '0 && inst_i.r.rs1 == locked_rd;
    assign hit_rs2 = use_rs2 && inst_i.r.rs2 != '0 && inst_i.r.rs2 == locked_rd;

    assign hazard_o = enable_i & (hit_rs1 | hit_rs2 | (use_mem & locked_mem));

    a_no_hazard_when_stalled: assert property (
        @(posedge clk) disable iff (reset) $rose(hazard_o) |-> enable_i
    );

endmodule

// File: logic/decode_stage.sv
/*
 * Decode stage top. rs1_data_i and rs2_data_i must answer rs1_o and rs2_o
 * within the same cycle. Output latency is one cycle, enable_i low stalls.
 */
module decode_stage
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable_i,
    input  rv_inst_u              instruction_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [TAG_W-1:0]      tag_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic                  access_fault_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  hazard_o,
    output decode_out_t           out_o
);

    rv_inst_u     inst;
    decode_info_t info;
    decode_out_t  accepted, bubble;

    inst_replay u_replay (.clk, .enable_i, .hazard_i(hazard_o), .instruction_i, .inst_o(inst));
    op_decoder  u_op     (.inst_i(inst), .op_o(info.op));
    imm_gen     u_imm    (.inst_i(inst), .format_o(info.format), .imm_o(info.imm));

    hazard_unit u_hazard (
        .clk, .reset, .enable_i, .inst_i(inst), .format_i(info.format), .hazard_o
    );

    assign rs1_o = inst.r.rs1;
    assign rs2_o = inst.r.rs2;

    ////////////////////////////////////////
    // Operand select and exception flags
    ////////////////////////////////////////

    always_comb begin
        accepted = '0;
        accepted.first_operand  = (info.format inside {U_TYPE, J_TYPE}) ? pc_i : rs1_data_i;
        accepted.second_operand = (info.format == R_TYPE) ? rs2_data_i : info.imm;
        accepted.third_operand  = (info.format == S_TYPE) ? rs2_data_i : info.imm;
        accepted.pc             = pc_i;
        accepted.rd             = inst.r.rd;
        accepted.op             = info.op;
        accepted.tag            = tag_i;
        accepted.illegal        = (info.op == INVALID);
        accepted.misaligned     = (pc_i[1:0] != 2'b00);
        accepted.access_fault   = access_fault_i;
    end

    always_comb begin
        bubble     = '0;
        bubble.op  = NOP;
        bubble.tag = tag_i;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_o    <= '0;
            out_o.op <= NOP;
        end else if (hazard_o) begin
            out_o <= bubble;
        end else if (enable_i) begin
            out_o <= accepted;
        end
    end

    a_bubble_is_clean: assert property (
        @(posedge clk) disable iff (reset)
        hazard_o |=> out_o.op == NOP && !out_o.illegal && !out_o.misaligned
    );

endmodule

// File: test/decode_tb.sv
/*
 * Testbench for decode_stage. The register bank is modelled as a fixed
 * scramble of the register index, answered in the same cycle.
 * Expected outputs come from a reference model of the replay and lock rules.
 */
module decode_tb
    import rv_isa_pkg::*;
    import decode_pkg::*;
();

    localparam int POOL_SIZE   = 400;
    localparam int CYCLE_LIMIT = 2000;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  enable_i;
    rv_inst_u              instruction_i;
    logic [XLEN-1:0]       pc_i;
    logic [TAG_W-1:0]      tag_i;
    logic [XLEN-1:0]       rs1_data_i;
    logic [XLEN-1:0]       rs2_data_i;
    logic                  access_fault_i;
    logic [REG_ADDR_W-1:0] rs1_o;
    logic [REG_ADDR_W-1:0] rs2_o;
    logic                  hazard_o;
    decode_out_t           out_o;

    // Reference model state, advanced once per cycle
    logic [31:0]           model_held   = 32'h0000_0013;
    logic                  model_replay = 1'b0;
    logic [REG_ADDR_W-1:0] lock_rd      = '0;
    logic                  lock_mem     = 1'b0;
    decode_out_t           exp_out      = '0;
    int                    cycles       = 0;
    int                    hazard_count = 0;
    int                    stall_count  = 0;

    logic [6:0]  legal_opcodes [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                       OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP,
                                       OPC_MISC_MEM, OPC_SYSTEM};
    // OP-V, LOAD-FP, STORE-FP and OP-32
    logic [6:0]  illegal_opcodes [4] = '{7'b1010111, 7'b0000111, 7'b0100111, 7'b0111011};
    logic [6:0]  funct7_picks [3]    = '{7'h00, 7'h20, 7'h01};
    logic [31:0] priv_words [5]      = '{32'h0000_0073, 32'h0010_0073, 32'h1020_0073,
                                        32'h3020_0073, 32'h1050_0073};

    decode_stage u_dut (
        .clk, .reset, .enable_i, .instruction_i, .pc_i, .tag_i, .rs1_data_i, .rs2_data_i,
        .access_fault_i, .rs1_o, .rs2_o, .hazard_o, .out_o
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] bank_read(input logic [REG_ADDR_W-1:0] idx);
        return {idx, 27'h0} ^ (32'h9e37_79b9 * {27'h0, idx}) ^ 32'h0001_2345;
    endfunction

    assign rs1_data_i = bank_read(rs1_o);
    assign rs2_data_i = bank_read(rs2_o);

    ////////////////////////////////////////
    // Reference decode
    ////////////////////////////////////////

    function automatic format_e ref_format(input logic [31:0] w);
        case (w[6:0])
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: return I_TYPE;
            OPC_STORE:                      return S_TYPE;
            OPC_BRANCH:                     return B_TYPE;
            OPC_LUI, OPC_AUIPC:             return U_TYPE;
            OPC_JAL:                        return J_TYPE;
            default:                        return R_TYPE;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] ref_imm(input logic [31:0] w, input format_e fmt);
        case (fmt)
            I_TYPE:  return {{20{w[31]}}, w[31:20]};
            S_TYPE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  return {w[31:12], 12'h0};
            J_TYPE:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    // Shared by OP and OP-IMM with funct7 zero
    function automatic op_e alu_op(input logic [2:0] f3);
        case (f3)
            3'd0:    return ADD;
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    function automatic op_e mul_op(input logic [2:0] f3);
        case (f3)
            3'd0:    return MUL;
            3'd1:    return MULH;
            3'd2:    return MULHSU;
            3'd3:    return MULHU;
            3'd4:    return DIV;
            3'd5:    return DIVU;
            3'd6:    return REM;
            default: return REMU;
        endcase
    endfunction

    function automatic op_e ref_op(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            OPC_LUI:   return LUI;
            OPC_AUIPC: return ADD;
            OPC_JAL:   return JAL;
            OPC_JALR:  return JALR;
            OPC_BRANCH: begin
                case (f3)
                    3'd0:    return BEQ;
                    3'd1:    return BNE;
                    3'd4:    return BLT;
                    3'd5:    return BGE;
                    3'd6:    return BLTU;
                    3'd7:    return BGEU;
                    default: return INVALID;
                endcase
            end
            OPC_LOAD: begin
                case (f3)
                    3'd0:    return LB;
                    3'd1:    return LH;
                    3'd2:    return LW;
                    3'd4:    return LBU;
                    3'd5:    return LHU;
                    default: return INVALID;
                endcase
            end
            OPC_STORE: begin
                case (f3)
                    3'd0:    return SB;
                    3'd1:    return SH;
                    3'd2:    return SW;
                    default: return INVALID;
                endcase
            end
            OPC_OP_IMM: begin
                if (f3 == 3'd1)
                    return (f7 == 7'h00) ? SLL : INVALID;
                if (f3 == 3'd5)
                    return (f7 == 7'h00) ? SRL : (f7 == 7'h20) ? SRA : INVALID;
                return alu_op(f3);
            end
            OPC_OP: begin
                if (f7 == 7'h00)
                    return alu_op(f3);
                if (f7 == 7'h01)
                    return mul_op(f3);
                if (f7 == 7'h20 && f3 == 3'd0)
                    return SUB;
                if (f7 == 7'h20 && f3 == 3'd5)
                    return SRA;
                return INVALID;
            end
            OPC_MISC_MEM: return (f3 == 3'd0) ? NOP : INVALID;
            OPC_SYSTEM: begin
                case (w)
                    32'h0000_0073: return ECALL;
                    32'h0010_0073: return EBREAK;
                    32'h1020_0073: return SRET;
                    32'h3020_0073: return MRET;
                    32'h1050_0073: return WFI;
                    default: ;
                endcase
                case (f3)
                    3'd1:    return CSRRW;
                    3'd2:    return CSRRS;
                    3'd3:    return CSRRC;
                    3'd5:    return CSRRWI;
                    3'd6:    return CSRRSI;
                    3'd7:    return CSRRCI;
                    default: return INVALID;
                endcase
            end
            default: return INVALID;
        endcase
    endfunction

    function automatic decode_out_t ref_decode(input logic [31:0] w, input logic [XLEN-1:0] pc,
                                               input logic [TAG_W-1:0] tag, input logic fault);
        decode_out_t     d;
        format_e         fmt;
        logic [XLEN-1:0] imm;
        fmt = ref_format(w);
        imm = ref_imm(w, fmt);
        d.first_operand  = (fmt == U_TYPE || fmt == J_TYPE) ? pc : bank_read(w[19:15]);
        d.second_operand = (fmt == R_TYPE) ? bank_read(w[24:20]) : imm;
        d.third_operand  = (fmt == S_TYPE) ? bank_read(w[24:20]) : imm;
        d.pc             = pc;
        d.rd             = w[11:7];
        d.op             = ref_op(w);
        d.tag            = tag;
        d.illegal        = (d.op == INVALID);
        d.misaligned     = (pc[1:0] != 2'b00);
        d.access_fault   = fault;
        return d;
    endfunction

    function automatic logic ref_hazard(input logic [31:0] w, input logic en,
                                        input logic [REG_ADDR_W-1:0] lrd, input logic lmem);
        format_e fmt;
        logic    hit1, hit2, mem;
        fmt  = ref_format(w);
        hit1 = (fmt != U_TYPE && fmt != J_TYPE) && w[19:15] != 5'd0 && w[19:15] == lrd;
        hit2 = (fmt inside {R_TYPE, S_TYPE, B_TYPE}) && w[24:20] != 5'd0 && w[24:20] == lrd;
        mem  = (w[6:0] == OPC_LOAD || w[6:0] == OPC_STORE) && lmem;
        return en && (hit1 || hit2 || mem);
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_out(input decode_out_t actual, input decode_out_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: out_o is %h (op %s), expected %h (op %s)", $time,
                     actual, actual.op.name(), expected, expected.op.name());
            $display("Test FAILED");
            $fatal(1, "out_o mismatch");
        end
    endtask

    task automatic check_hazard(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t: hazard_o is %b, expected %b", $time, actual, expected);
            $display("Test FAILED");
            $fatal(1, "hazard_o mismatch");
        end
    endtask

    task automatic check_index(input string name, input logic [REG_ADDR_W-1:0] actual,
                               input logic [REG_ADDR_W-1:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "register index mismatch");
        end
    endtask

    // Inputs are stable at the falling edge, so the model steps there
    always @(negedge clk) begin : compare
        logic [31:0] word;
        logic        hz;
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the stimulus did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
        word = model_replay ? model_held : 32'(instruction_i);
        hz   = ref_hazard(word, enable_i, lock_rd, lock_mem);
        check_index("rs1_o", rs1_o, word[19:15]);
        check_index("rs2_o", rs2_o, word[24:20]);
        check_hazard(hazard_o, hz);
        check_out(out_o, exp_out);
        // Expected result of the coming rising edge
        if (reset) begin
            exp_out    = '0;
            exp_out.op = NOP;
            lock_rd    = '0;
            lock_mem   = 1'b0;
        end else if (hz) begin
            exp_out     = '0;
            exp_out.op  = NOP;
            exp_out.tag = tag_i;
            lock_rd     = '0;
            lock_mem    = 1'b0;
            hazard_count++;
        end else if (enable_i) begin
            exp_out  = ref_decode(word, pc_i, tag_i, access_fault_i);
            lock_rd  = word[11:7];
            lock_mem = (word[6:0] == OPC_STORE);
        end else begin
            stall_count++;
        end
        model_held   = word;
        model_replay = hz || !enable_i;
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Small register indices keep hazards frequent
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = $urandom;
        if ($urandom_range(7, 0) == 0) begin
            w[6:0] = illegal_opcodes[2'($urandom_range(3, 0))];
            return w;
        end
        w[6:0]   = legal_opcodes[4'($urandom_range(10, 0))];
        w[11:7]  = 5'($urandom_range(3, 0));
        w[19:15] = 5'($urandom_range(3, 0));
        w[24:20] = 5'($urandom_range(3, 0));
        if (w[6:0] inside {OPC_OP, OPC_OP_IMM} && $urandom_range(3, 0) != 0)
            w[31:25] = funct7_picks[2'($urandom_range(2, 0))];
        if (w[6:0] == OPC_SYSTEM && w[14:12] == 3'b000)
            w = priv_words[3'($urandom_range(4, 0))];
        return w;
    endfunction

    initial begin : stimulus
        logic [31:0]     pool [$];
        logic [XLEN-1:0] pc_next;
        void'($urandom(18475));
        reset          = 1'b1;
        enable_i       = 1'b1;
        instruction_i  = 32'h0000_0013;
        pc_i           = '0;
        tag_i          = '0;
        access_fault_i = 1'b0;
        for (int i = 0; i < POOL_SIZE; i++)
            pool.push_back(random_word());

        repeat (2) @(posedge clk);
        while (pool.size() > 0) begin
            @(posedge clk);
            reset          <= 1'b0;
            enable_i       <= $urandom_range(9, 0) < 8;
            tag_i          <= TAG_W'($urandom);
            access_fault_i <= $urandom_range(7, 0) == 0;
            pc_next = $urandom;
            pc_next[1:0] = ($urandom_range(7, 0) == 0) ? 2'($urandom_range(3, 1)) : 2'b00;
            pc_i <= pc_next;
            // A replay cycle ignores instruction_i, so the next word waits
            if (!model_replay)
                instruction_i <= pool.pop_front();
        end

        // Let the last word leave the replay register
        do begin
            @(posedge clk);
            enable_i <= 1'b1;
            if (!model_replay)
                instruction_i <= 32'h0000_0013;
        end while (model_replay);
        repeat (2) @(posedge clk);

        if (hazard_count == 0 || stall_count == 0) begin
            $display("The run saw %0d hazards and %0d stalls, both must occur",
                     hazard_count, stall_count);
            $display("Test FAILED");
            $fatal(1, "stimulus did not cover hazards and stalls");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: verilog.f
logic/rv_isa_pkg.sv
logic/decode_pkg.sv
logic/inst_replay.sv
logic/op_decoder.sv
logic/imm_gen.sv
logic/hazard_unit.sv
logic/decode_stage.sv
test/decode_tb.sv

// File: run.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module decode_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vdecode_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

exit 0
